// ==== pim_ctrl_pkg.sv ====
package pim_ctrl_pkg;

    // bus word, used for both address and data
    typedef logic [31:0] word_t;

    // command operand fields
    typedef logic [6:0]  row_addr_t;     // cmd addr [15:9]
    typedef logic [8:0]  col_addr_t;     // cmd addr [8:0]
    typedef logic [16:0] pulse_width_t;  // cmd data [21:5]
    typedef logic [4:0]  pulse_count_t;  // cmd data [4:0]
    typedef logic [3:0]  rx_cnt_t;       // cmd addr [19:16]

    typedef logic [3:0]  exec_cnt_t;

    // codes 4, 6 and 7 are not accepted
    typedef enum logic [2:0] {
        MODE_NONE     = 3'd0,
        MODE_ERASE    = 3'd1,
        MODE_PROGRAM  = 3'd2,
        MODE_READ     = 3'd3,
        MODE_PARALLEL = 3'd5
    } pim_mode_t;

    // register map
    localparam word_t       MODE_ADDR   = 32'h4100_0000;
    localparam word_t       STATUS_ADDR = 32'h4300_0000;
    localparam logic [11:0] CMD_PREFIX  = 12'h400;  // top 12 bits of a command address

    // sequencing lengths
    localparam exec_cnt_t   READ_CYCLES     = 4'd9;
    localparam exec_cnt_t   PARALLEL_CYCLES = 4'd12;
    localparam int unsigned OUTPUT_WAIT     = 2;     // idle cycles before output strobe

    // status word: bit 1 data valid, bit 0 idle
    localparam word_t       STATUS_IDLE = 32'h0000_0003;
    localparam word_t       STATUS_BUSY = 32'h0000_0002;

endpackage

// ==== pim_cmd_decode.sv ====
`timescale 1ns/1ps

module pim_cmd_decode (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       bus_req_i,
    input  logic                       bus_we_i,
    input  pim_ctrl_pkg::word_t        bus_addr_i,
    input  pim_ctrl_pkg::word_t        bus_wdata_i,
    input  logic                       exec_ack_i,
    input  logic                       out_ack_i,

    output logic                       bus_ack_o,
    output logic                       status_rd_o,
    output logic                       busy_o,

    output logic                       exec_req_o,
    output pim_ctrl_pkg::pim_mode_t    mode_o,
    output pim_ctrl_pkg::row_addr_t    row_o,
    output pim_ctrl_pkg::col_addr_t    col_o,
    output pim_ctrl_pkg::pulse_width_t width_o,
    output pim_ctrl_pkg::pulse_count_t count_o,

    output pim_ctrl_pkg::word_t        input_data_o,
    output pim_ctrl_pkg::rx_cnt_t      data_rx_cnt_o,
    output logic                       in_buf_write_o,

    output logic                       out_req_o
);

    import pim_ctrl_pkg::*;

    typedef enum logic [2:0] {
        IDLE        = 3'b000,
        WAIT_MODE   = 3'b001,
        MODE_READY  = 3'b010,
        MODE_EXEC   = 3'b100,
        MODE_OUTPUT = 3'b101
    } state_t;

    state_t    state_q;
    logic      accept;      // req seen while ack still low
    logic      mode_wr;
    logic      cmd_wr;
    logic      mode_legal;
    pim_mode_t wr_mode;

    assign accept  = bus_req_i && !bus_ack_o;
    assign wr_mode = pim_mode_t'(bus_wdata_i[2:0]);

    always_comb begin
        case (wr_mode)
            MODE_ERASE, MODE_PROGRAM, MODE_READ, MODE_PARALLEL: mode_legal = 1'b1;
            default:                                            mode_legal = 1'b0;
        endcase
    end

    assign status_rd_o = accept && !bus_we_i && (bus_addr_i == STATUS_ADDR);
    assign mode_wr     = accept && bus_we_i && (bus_addr_i == MODE_ADDR)
                         && (state_q == WAIT_MODE) && mode_legal;
    assign cmd_wr      = accept && bus_we_i && (bus_addr_i[31:20] == CMD_PREFIX)
                         && (state_q == MODE_READY);

    assign busy_o = (state_q != IDLE) && (state_q != WAIT_MODE);

    // four-phase bus, every request gets an ack
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bus_ack_o <= 1'b0;
        end else if (accept) begin
            bus_ack_o <= 1'b1;
        end else if (!bus_req_i) begin
            bus_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= IDLE;
            mode_o         <= MODE_NONE;
            exec_req_o     <= 1'b0;
            out_req_o      <= 1'b0;
            in_buf_write_o <= 1'b0;
            input_data_o   <= '0;
            data_rx_cnt_o  <= '0;
        end else begin
            in_buf_write_o <= 1'b0;  // single-cycle write strobe
            input_data_o   <= '0;
            data_rx_cnt_o  <= '0;
            case (state_q)
                IDLE: begin
                    if (status_rd_o) begin
                        state_q <= WAIT_MODE;
                    end
                end
                WAIT_MODE: begin
                    if (mode_wr) begin
                        mode_o  <= wr_mode;
                        state_q <= MODE_READY;
                    end
                end
                MODE_READY: begin
                    if (cmd_wr) begin
                        exec_req_o <= 1'b1;  // rises together with bus ack
                        state_q    <= MODE_EXEC;
                        if (mode_o == MODE_PARALLEL) begin
                            in_buf_write_o <= 1'b1;
                            input_data_o   <= bus_wdata_i;
                            data_rx_cnt_o  <= bus_addr_i[19:16];
                        end
                    end
                end
                MODE_EXEC: begin
                    if (exec_req_o) begin
                        if (exec_ack_i) begin
                            exec_req_o <= 1'b0;
                        end
                    end else if (!exec_ack_i) begin  // handshake closed
                        if (mode_o == MODE_PARALLEL) begin
                            out_req_o <= 1'b1;
                            state_q   <= MODE_OUTPUT;
                        end else begin
                            state_q <= IDLE;
                        end
                    end
                end
                MODE_OUTPUT: begin
                    if (out_req_o) begin
                        if (out_ack_i) begin
                            out_req_o <= 1'b0;
                        end
                    end else if (!out_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // operands stay put until the next command
    always_ff @(posedge clk_i) begin
        if (cmd_wr) begin
            row_o   <= bus_addr_i[15:9];
            col_o   <= bus_addr_i[8:0];
            width_o <= bus_wdata_i[21:5];
            count_o <= bus_wdata_i[4:0];
        end
    end

endmodule

// ==== pim_exec_seq.sv ====
`timescale 1ns/1ps

module pim_exec_seq (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       exec_req_i,
    input  pim_ctrl_pkg::pim_mode_t    mode_i,
    input  pim_ctrl_pkg::row_addr_t    row_i,
    input  pim_ctrl_pkg::col_addr_t    col_i,
    input  pim_ctrl_pkg::pulse_width_t width_i,
    input  pim_ctrl_pkg::pulse_count_t count_i,

    output logic                       exec_ack_o,

    // flash row driver
    output logic                       pim_en_o,
    output pim_ctrl_pkg::pim_mode_t    pim_mode_o,
    output pim_ctrl_pkg::row_addr_t    row_addr_o,
    output pim_ctrl_pkg::col_addr_t    col_addr_o,
    output pim_ctrl_pkg::exec_cnt_t    exec_cnt_o,
    output logic                       in_buf_read_o
);

    import pim_ctrl_pkg::*;

    typedef enum logic [2:0] {
        E_IDLE  = 3'd0,
        E_PULSE = 3'd1,   // pim_en high, width counting down
        E_GAP   = 3'd2,   // one low cycle between pulses
        E_COUNT = 3'd3,   // fixed countdown for read and parallel
        E_ACK   = 3'd4
    } state_t;

    state_t       state_q;
    pulse_width_t width_q;
    pulse_width_t width_reload_q;
    pulse_count_t count_q;
    exec_cnt_t    cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= E_IDLE;
            width_q        <= '0;
            width_reload_q <= '0;
            count_q        <= '0;
            cnt_q          <= '0;
        end else begin
            case (state_q)
                E_IDLE: begin
                    if (exec_req_i) begin
                        width_q        <= width_i;
                        width_reload_q <= width_i;
                        count_q        <= count_i;
                        case (mode_i)
                            MODE_ERASE, MODE_PROGRAM: begin
                                // zero width or count means nothing to drive
                                if ((width_i != '0) && (count_i != '0)) begin
                                    state_q <= E_PULSE;
                                end else begin
                                    state_q <= E_ACK;
                                end
                            end
                            MODE_READ: begin
                                cnt_q   <= READ_CYCLES;
                                state_q <= E_COUNT;
                            end
                            MODE_PARALLEL: begin
                                cnt_q   <= PARALLEL_CYCLES;
                                state_q <= E_COUNT;
                            end
                            default: begin
                                state_q <= E_ACK;
                            end
                        endcase
                    end
                end
                E_PULSE: begin
                    width_q <= width_q - 1'b1;
                    if (width_q == pulse_width_t'(1)) begin
                        state_q <= E_GAP;
                    end
                end
                E_GAP: begin
                    count_q <= count_q - 1'b1;
                    width_q <= width_reload_q;
                    if (count_q == pulse_count_t'(1)) begin
                        state_q <= E_ACK;  // last pulse done
                    end else begin
                        state_q <= E_PULSE;
                    end
                end
                E_COUNT: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == exec_cnt_t'(1)) begin
                        state_q <= E_ACK;
                    end
                end
                E_ACK: begin
                    if (!exec_req_i) begin
                        state_q <= E_IDLE;
                    end
                end
                default: begin
                    state_q <= E_IDLE;
                end
            endcase
        end
    end

    assign exec_ack_o = (state_q == E_ACK);
    assign pim_en_o   = (state_q == E_PULSE) || (state_q == E_COUNT);

    // driver outputs only carry values while enabled
    always_comb begin
        pim_mode_o    = MODE_NONE;
        row_addr_o    = '0;
        col_addr_o    = '0;
        exec_cnt_o    = '0;
        in_buf_read_o = 1'b0;
        if (pim_en_o) begin
            pim_mode_o = mode_i;
            row_addr_o = row_i;
            if (mode_i != MODE_ERASE) begin
                col_addr_o = col_i;  // erase works on a whole row
            end
            if (state_q == E_COUNT) begin
                exec_cnt_o = cnt_q;
            end
            in_buf_read_o = (mode_i == MODE_PARALLEL);
        end
    end

endmodule

// ==== pim_result_seq.sv ====
`timescale 1ns/1ps

module pim_result_seq (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                out_req_i,
    input  logic                status_rd_i,
    input  logic                busy_i,

    output logic                out_ack_o,

    // output processing
    output logic                buf_read_en_o,
    output logic                shift_counter_en_o,

    output pim_ctrl_pkg::word_t bus_rdata_o
);

    import pim_ctrl_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE   = 2'd0,
        R_WAIT   = 2'd1,
        R_STROBE = 2'd2,
        R_ACK    = 2'd3
    } state_t;

    state_t     state_q;
    logic [1:0] wait_q;   // remaining idle cycles
    logic       busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= R_IDLE;
            wait_q  <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    if (out_req_i) begin
                        wait_q  <= 2'(OUTPUT_WAIT - 1);
                        state_q <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (wait_q == '0) begin
                        state_q <= R_STROBE;
                    end else begin
                        wait_q <= wait_q - 1'b1;
                    end
                end
                R_STROBE: begin
                    state_q <= R_ACK;
                end
                R_ACK: begin
                    if (!out_req_i) begin
                        state_q <= R_IDLE;
                    end
                end
                default: begin
                    state_q <= R_IDLE;
                end
            endcase
        end
    end

    assign out_ack_o          = (state_q == R_ACK);
    assign buf_read_en_o      = (state_q == R_STROBE);
    assign shift_counter_en_o = (state_q == R_STROBE);  // same cycle as buffer read

    // status word, loaded as the read is acked
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bus_rdata_o <= '0;
            busy_q      <= 1'b0;
        end else begin
            busy_q <= busy_i;
            if (status_rd_i) begin
                bus_rdata_o <= busy_i ? STATUS_BUSY : STATUS_IDLE;
            end else if (busy_i && !busy_q) begin
                bus_rdata_o <= '0;  // a new command sequence has begun
            end
        end
    end

endmodule

// ==== pim_ctrl_top.sv ====
`timescale 1ns/1ps

module pim_ctrl_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // cpu register bus
    input  logic                    bus_req_i,
    input  logic                    bus_we_i,
    input  pim_ctrl_pkg::word_t     bus_addr_i,
    input  pim_ctrl_pkg::word_t     bus_wdata_i,
    output logic                    bus_ack_o,
    output pim_ctrl_pkg::word_t     bus_rdata_o,

    // flash row driver
    output logic                    pim_en_o,
    output pim_ctrl_pkg::pim_mode_t pim_mode_o,
    output pim_ctrl_pkg::exec_cnt_t exec_cnt_o,
    output pim_ctrl_pkg::row_addr_t row_addr_o,
    output pim_ctrl_pkg::col_addr_t col_addr_o,

    // input buffer
    output pim_ctrl_pkg::word_t     input_data_o,
    output pim_ctrl_pkg::rx_cnt_t   data_rx_cnt_o,
    output logic                    in_buf_write_o,
    output logic                    in_buf_read_o,

    // output processing
    output logic                    buf_read_en_o,
    output logic                    shift_counter_en_o
);

    import pim_ctrl_pkg::*;

    logic         exec_req;
    logic         exec_ack;
    logic         out_req;
    logic         out_ack;
    logic         status_rd;
    logic         busy;
    pim_mode_t    mode;
    row_addr_t    row;
    col_addr_t    col;
    pulse_width_t width;
    pulse_count_t count;

    pim_cmd_decode u_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .bus_req_i      (bus_req_i),
        .bus_we_i       (bus_we_i),
        .bus_addr_i     (bus_addr_i),
        .bus_wdata_i    (bus_wdata_i),
        .exec_ack_i     (exec_ack),
        .out_ack_i      (out_ack),
        .bus_ack_o      (bus_ack_o),
        .status_rd_o    (status_rd),
        .busy_o         (busy),
        .exec_req_o     (exec_req),
        .mode_o         (mode),
        .row_o          (row),
        .col_o          (col),
        .width_o        (width),
        .count_o        (count),
        .input_data_o   (input_data_o),
        .data_rx_cnt_o  (data_rx_cnt_o),
        .in_buf_write_o (in_buf_write_o),
        .out_req_o      (out_req)
    );

    pim_exec_seq u_exec (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .exec_req_i    (exec_req),
        .mode_i        (mode),
        .row_i         (row),
        .col_i         (col),
        .width_i       (width),
        .count_i       (count),
        .exec_ack_o    (exec_ack),
        .pim_en_o      (pim_en_o),
        .pim_mode_o    (pim_mode_o),
        .row_addr_o    (row_addr_o),
        .col_addr_o    (col_addr_o),
        .exec_cnt_o    (exec_cnt_o),
        .in_buf_read_o (in_buf_read_o)
    );

    pim_result_seq u_result (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .out_req_i          (out_req),
        .status_rd_i        (status_rd),
        .busy_i             (busy),
        .out_ack_o          (out_ack),
        .buf_read_en_o      (buf_read_en_o),
        .shift_counter_en_o (shift_counter_en_o),
        .bus_rdata_o        (bus_rdata_o)
    );

endmodule

// ==== pim_ctrl_sva.sv ====
`timescale 1ns/1ps

module pim_ctrl_sva (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    bus_req_i,
    input  logic                    bus_ack_i,
    input  logic                    exec_req_i,
    input  logic                    exec_ack_i,
    input  logic                    pim_en_i,
    input  pim_ctrl_pkg::pim_mode_t pim_mode_i,
    input  pim_ctrl_pkg::row_addr_t row_addr_i,
    input  pim_ctrl_pkg::col_addr_t col_addr_i,
    input  pim_ctrl_pkg::exec_cnt_t exec_cnt_i,
    input  logic                    in_buf_read_i
);

    import pim_ctrl_pkg::*;

    int fail_cnt = 0;  // read by the testbench at the end

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(bus_ack_i) |-> $past(bus_req_i))
        else begin
            $error("bus ack rose without a pending req");
            fail_cnt++;
        end

    // exec handshake is four-phase, req may only fall after ack
    exec_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exec_req_i && !exec_ack_i |=> exec_req_i)
        else begin
            $error("exec req dropped before exec ack");
            fail_cnt++;
        end

    idle_outputs_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !pim_en_i |-> (pim_mode_i == MODE_NONE) && (row_addr_i == '0) && (col_addr_i == '0)
                      && (exec_cnt_i == '0) && !in_buf_read_i)
        else begin
            $error("row driver outputs not zero while pim_en is low");
            fail_cnt++;
        end

endmodule

bind pim_ctrl_top pim_ctrl_sva u_sva (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_req_i     (bus_req_i),
    .bus_ack_i     (bus_ack_o),
    .exec_req_i    (exec_req),
    .exec_ack_i    (exec_ack),
    .pim_en_i      (pim_en_o),
    .pim_mode_i    (pim_mode_o),
    .row_addr_i    (row_addr_o),
    .col_addr_i    (col_addr_o),
    .exec_cnt_i    (exec_cnt_o),
    .in_buf_read_i (in_buf_read_o)
);

// ==== pim_ctrl_monitor.sv ====
`timescale 1ns/1ps

module pim_ctrl_monitor (
    input  logic                    clk_i,
    input  logic                    pim_en_i,
    input  pim_ctrl_pkg::pim_mode_t pim_mode_i,
    input  pim_ctrl_pkg::exec_cnt_t exec_cnt_i,
    input  pim_ctrl_pkg::row_addr_t row_addr_i,
    input  pim_ctrl_pkg::col_addr_t col_addr_i,
    input  pim_ctrl_pkg::word_t     input_data_i,
    input  pim_ctrl_pkg::rx_cnt_t   data_rx_cnt_i,
    input  logic                    in_buf_write_i,
    input  logic                    in_buf_read_i,
    input  logic                    buf_read_en_i,
    input  logic                    shift_counter_en_i
);

    import pim_ctrl_pkg::*;

    string     test_name;
    pim_mode_t exp_mode;
    row_addr_t exp_row;
    col_addr_t exp_col;
    exec_cnt_t exp_cnt;   // next expected countdown value
    word_t     exp_data;
    rx_cnt_t   exp_rx;
    int        exp_high;
    int        exp_pulses;
    int        exp_writes;
    int        exp_strobes;
    int        high_cnt;
    int        pulse_cnt;
    int        write_cnt;
    int        strobe_cnt;
    int        err_cnt = 0;
    int        test_cnt = 0;
    int        err_at_start;
    logic      en_q = 1'b0;

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name, input pim_mode_t mode, input row_addr_t row,
                              input col_addr_t col, input exec_cnt_t cnt, input word_t data,
                              input rx_cnt_t rx, input int high, input int pulses,
                              input int writes, input int strobes);
        test_name    = name;
        exp_mode     = mode;
        exp_row      = row;
        exp_col      = col;
        exp_cnt      = cnt;
        exp_data     = data;
        exp_rx       = rx;
        exp_high     = high;
        exp_pulses   = pulses;
        exp_writes   = writes;
        exp_strobes  = strobes;
        high_cnt     = 0;
        pulse_cnt    = 0;
        write_cnt    = 0;
        strobe_cnt   = 0;
        err_at_start = err_cnt;
    endtask

    task automatic finish_test();
        compare_word("pim_en_o high cycles", high_cnt, exp_high);
        compare_word("pim_en_o pulses", pulse_cnt, exp_pulses);
        compare_word("in_buf_write_o pulses", write_cnt, exp_writes);
        compare_word("buf_read_en_o pulses", strobe_cnt, exp_strobes);
        test_cnt++;
        if (err_cnt == err_at_start) begin
            $display("test %0d %s: ok", test_cnt, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, test_name, err_cnt - err_at_start);
        end
    endtask

    task automatic check_outputs_zero();
        compare_word("pim_en_o", pim_en_i, 0);
        compare_word("pim_mode_o", pim_mode_i, 0);
        compare_word("exec_cnt_o", exec_cnt_i, 0);
        compare_word("row_addr_o", row_addr_i, 0);
        compare_word("col_addr_o", col_addr_i, 0);
        compare_word("input_data_o", input_data_i, 0);
        compare_word("data_rx_cnt_o", data_rx_cnt_i, 0);
        compare_word("in_buf_write_o", in_buf_write_i, 0);
        compare_word("in_buf_read_o", in_buf_read_i, 0);
        compare_word("buf_read_en_o", buf_read_en_i, 0);
        compare_word("shift_counter_en_o", shift_counter_en_i, 0);
    endtask

    // sampled mid-cycle, away from the edges
    always @(negedge clk_i) begin
        if (pim_en_i) begin
            high_cnt++;
            if (!en_q) begin
                pulse_cnt++;
            end
            compare_word("pim_mode_o", pim_mode_i, exp_mode);
            compare_word("row_addr_o", row_addr_i, exp_row);
            compare_word("col_addr_o", col_addr_i, exp_col);
            compare_word("exec_cnt_o", exec_cnt_i, exp_cnt);
            compare_word("in_buf_read_o", in_buf_read_i, exp_mode == MODE_PARALLEL);
            if (exp_cnt != '0) begin
                exp_cnt--;  // read and parallel count down
            end
        end
        if (in_buf_write_i) begin
            write_cnt++;
            compare_word("input_data_o", input_data_i, exp_data);
            compare_word("data_rx_cnt_o", data_rx_cnt_i, exp_rx);
            if (high_cnt != 0) begin
                $display("in_buf_write_o pulsed after the execute cycles had started");
                err_cnt++;
            end
        end
        if (buf_read_en_i || shift_counter_en_i) begin
            strobe_cnt++;
            compare_word("shift_counter_en_o", shift_counter_en_i, buf_read_en_i);
            if (pim_en_i || (high_cnt != exp_high)) begin
                $display("output strobe came before the execute cycles had ended");
                err_cnt++;
            end
        end
        en_q = pim_en_i;
    end

endmodule

// ==== tb_pim_ctrl.sv ====
`timescale 1ns/1ps

module tb_pim_ctrl;

    import pim_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 50;    // cycles per handshake phase
    localparam int POLL_LIMIT = 200;   // status reads per operation

    logic      clk_i;
    logic      rst_ni;
    logic      bus_req_i;
    logic      bus_we_i;
    word_t     bus_addr_i;
    word_t     bus_wdata_i;
    logic      bus_ack_o;
    word_t     bus_rdata_o;
    logic      pim_en_o;
    pim_mode_t pim_mode_o;
    exec_cnt_t exec_cnt_o;
    row_addr_t row_addr_o;
    col_addr_t col_addr_o;
    word_t     input_data_o;
    rx_cnt_t   data_rx_cnt_o;
    logic      in_buf_write_o;
    logic      in_buf_read_o;
    logic      buf_read_en_o;
    logic      shift_counter_en_o;
    integer    seed;
    word_t     rd;
    row_addr_t row;
    col_addr_t col;
    int        errors;

    pim_ctrl_top u_dut (.*);

    pim_ctrl_monitor u_mon (
        .clk_i              (clk_i),
        .pim_en_i           (pim_en_o),
        .pim_mode_i         (pim_mode_o),
        .exec_cnt_i         (exec_cnt_o),
        .row_addr_i         (row_addr_o),
        .col_addr_i         (col_addr_o),
        .input_data_i       (input_data_o),
        .data_rx_cnt_i      (data_rx_cnt_o),
        .in_buf_write_i     (in_buf_write_o),
        .in_buf_read_i      (in_buf_read_o),
        .buf_read_en_i      (buf_read_en_o),
        .shift_counter_en_i (shift_counter_en_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        @(posedge clk_i);
        while ((bus_ack_o !== level) && (n < WAIT_LIMIT)) begin
            n++;
            @(posedge clk_i);
        end
        if (bus_ack_o !== level) begin
            abort_on_timeout(level ? "bus ack to rise" : "bus ack to fall");
        end
    endtask

    task automatic bus_write(input word_t addr, input word_t data);
        @(posedge clk_i);
        bus_req_i   <= 1'b1;
        bus_we_i    <= 1'b1;
        bus_addr_i  <= addr;
        bus_wdata_i <= data;
        wait_ack(1'b1);
        bus_req_i <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic bus_read(input word_t addr, output word_t data);
        @(posedge clk_i);
        bus_req_i  <= 1'b1;
        bus_we_i   <= 1'b0;
        bus_addr_i <= addr;
        wait_ack(1'b1);
        data = bus_rdata_o;  // valid while ack is high
        bus_req_i <= 1'b0;
        wait_ack(1'b0);
    endtask

    // poll the status register until the operation has ended
    task automatic wait_idle();
        word_t status;
        int    n;
        n = 0;
        bus_read(STATUS_ADDR, status);
        while ((status !== STATUS_IDLE) && (n < POLL_LIMIT)) begin
            if (status !== STATUS_BUSY) begin
                u_mon.compare_word("bus_rdata_o", status, STATUS_BUSY);
            end
            n++;
            bus_read(STATUS_ADDR, status);
        end
        if (status !== STATUS_IDLE) begin
            abort_on_timeout("the status register to report idle");
        end
    endtask

    task automatic start_cmd(input pim_mode_t mode, input word_t addr, input word_t data);
        word_t status;
        bus_read(STATUS_ADDR, status);
        u_mon.compare_word("bus_rdata_o", status, STATUS_IDLE);
        bus_write(MODE_ADDR, word_t'(mode));
        bus_write(addr, data);
    endtask

    task automatic pulse_test(input pim_mode_t mode);
        row_addr_t    r;
        col_addr_t    c;
        pulse_width_t width;
        pulse_count_t count;
        int           high;
        r     = row_addr_t'($random(seed));
        c     = col_addr_t'($random(seed));
        width = pulse_width_t'(1 + $unsigned($random(seed)) % 40);
        count = pulse_count_t'($unsigned($random(seed)) % 7);
        high  = width * count;
        u_mon.begin_test(mode == MODE_ERASE ? "erase" : "program", mode, r,
                         (mode == MODE_ERASE) ? col_addr_t'(0) : c, 0, 0, 0,
                         high, count, 0, 0);
        start_cmd(mode, {CMD_PREFIX, 4'h0, r, c}, {10'h0, width, count});
        wait_idle();
        u_mon.finish_test();
    endtask

    // read and parallel run a fixed length
    task automatic count_test(input pim_mode_t mode);
        row_addr_t r;
        col_addr_t c;
        rx_cnt_t   rx;
        word_t     data;
        exec_cnt_t cycles;
        int        par;
        r      = row_addr_t'($random(seed));
        c      = col_addr_t'($random(seed));
        rx     = rx_cnt_t'($random(seed));
        data   = $random(seed);
        par    = (mode == MODE_PARALLEL);
        cycles = par ? PARALLEL_CYCLES : READ_CYCLES;
        u_mon.begin_test(par ? "parallel" : "read", mode, r, c, cycles, data, rx,
                         cycles, 1, par, par);
        start_cmd(mode, {CMD_PREFIX, rx, r, c}, data);
        wait_idle();
        u_mon.finish_test();
    endtask

    initial begin
        seed        = 33094;
        rst_ni      = 1'b0;
        bus_req_i   = 1'b0;
        bus_we_i    = 1'b0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        u_mon.begin_test("reset", MODE_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        @(posedge clk_i);
        u_mon.check_outputs_zero();
        u_mon.compare_word("bus_ack_o", bus_ack_o, 0);
        u_mon.compare_word("bus_rdata_o", bus_rdata_o, 0);
        bus_read(STATUS_ADDR, rd);
        u_mon.compare_word("bus_rdata_o", rd, STATUS_IDLE);
        u_mon.finish_test();

        for (int i = 0; i < 6; i++) begin
            pulse_test((i % 2) ? MODE_PROGRAM : MODE_ERASE);
        end
        for (int i = 0; i < 4; i++) begin
            count_test((i % 2) ? MODE_PARALLEL : MODE_READ);
        end

        // status reads busy during a long pulse train
        row = row_addr_t'($random(seed));
        col = col_addr_t'($random(seed));
        u_mon.begin_test("busy status", MODE_PROGRAM, row, col, 0, 0, 0, 40 * 6, 6, 0, 0);
        start_cmd(MODE_PROGRAM, {CMD_PREFIX, 4'h0, row, col}, {10'h0, 17'd40, 5'd6});
        bus_read(STATUS_ADDR, rd);
        u_mon.compare_word("bus_rdata_o", rd, STATUS_BUSY);
        wait_idle();
        u_mon.finish_test();

        u_mon.begin_test("illegal mode", MODE_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        bus_read(STATUS_ADDR, rd);
        u_mon.compare_word("bus_rdata_o", rd, STATUS_IDLE);
        bus_write(MODE_ADDR, 32'd4);
        bus_write(MODE_ADDR, 32'd6);
        bus_write(MODE_ADDR, 32'd7);
        bus_read(STATUS_ADDR, rd);
        u_mon.compare_word("bus_rdata_o", rd, STATUS_IDLE);  // no mode taken
        bus_write({CMD_PREFIX, 4'h0, row, col}, {10'h0, 17'd5, 5'd2});
        wait_idle();
        u_mon.finish_test();

        // reset returns the decoder to idle
        @(posedge clk_i);
        rst_ni <= 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        u_mon.begin_test("mode without status", MODE_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        bus_write(MODE_ADDR, word_t'(MODE_READ));
        bus_write({CMD_PREFIX, 4'h0, row, col}, 32'h0);
        wait_idle();
        u_mon.finish_test();

        row = row_addr_t'($random(seed));
        col = col_addr_t'($random(seed));
        u_mon.begin_test("wrong prefix", MODE_READ, row, col, READ_CYCLES, 0, 0,
                         READ_CYCLES, 1, 0, 0);
        bus_read(STATUS_ADDR, rd);
        u_mon.compare_word("bus_rdata_o", rd, STATUS_IDLE);
        bus_write(MODE_ADDR, word_t'(MODE_READ));
        bus_write({12'h401, 4'h0, ~row, col}, 32'h0);  // other row shows if taken
        bus_write({CMD_PREFIX, 4'h0, row, col}, 32'h0);
        wait_idle();
        u_mon.finish_test();

        errors = u_mon.err_cnt + u_dut.u_sva.fail_cnt;
        $display("%0d tests, %0d errors", u_mon.test_cnt, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
pim_ctrl_pkg.sv
pim_cmd_decode.sv
pim_exec_seq.sv
pim_result_seq.sv
pim_ctrl_top.sv
pim_ctrl_sva.sv
pim_ctrl_monitor.sv
tb_pim_ctrl.sv
